// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing -f compile.f --top-module tb_rv_core -o tb_rv_core
	@out=$$(./obj_dir/tb_rv_core); echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

lint:
	verilator --lint-only --timing -f compile.f --top-module tb_rv_core

clean:
	rm -rf obj_dir

// ==== compile.f ====
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_imm_gen.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_pc_unit.sv
src/rv_core.sv
testbench/tb_rv_model.sv
testbench/tb_rv_core.sv

// ==== src/rv_core.sv ====
module rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [XLEN-1:0]       Q_ROM,
    output logic [ADDR_WIDTH-1:0] ADDR_ROM,
    output logic [ADDR_WIDTH-1:0] ADDR_RAM,
    input  logic [XLEN-1:0]       Q_RAM,
    output logic [XLEN-1:0]       Q_W,
    output logic                  ENABLE_W
);

    logic                      reg_write;
    logic                      mem_write;
    logic                      alu_src_b;
    logic                      branch;
    logic                      jump;
    logic                      jump_reg;
    src_a_e                    src_a;
    wb_sel_e                   wb_sel;
    alu_op_e                   alu_op;
    logic [XLEN-1:0]           imm;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           alu_result;
    logic                      branch_taken;
    logic [XLEN-1:0]           pc;
    logic [XLEN-1:0]           pc_plus4;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [FUNCT3_WIDTH-1:0]   funct3;

    assign rs1_addr = Q_ROM[RS1_LSB +: REG_ADDR_WIDTH];
    assign rs2_addr = Q_ROM[RS2_LSB +: REG_ADDR_WIDTH];
    assign rd_addr  = Q_ROM[RD_LSB +: REG_ADDR_WIDTH];
    assign funct3   = Q_ROM[FUNCT3_LSB +: FUNCT3_WIDTH];

    rv_decoder decoder_i (
        .instr     (Q_ROM),
        .reg_write (reg_write),
        .mem_write (mem_write),
        .alu_src_b (alu_src_b),
        .branch    (branch),
        .jump      (jump),
        .jump_reg  (jump_reg),
        .src_a     (src_a),
        .wb_sel    (wb_sel),
        .alu_op    (alu_op)
    );

    rv_imm_gen imm_gen_i (
        .instr (Q_ROM),
        .imm   (imm)
    );

    rv_regfile regfile_i (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_addr    (rd_addr),
        .reg_write  (reg_write),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .mem_data   (Q_RAM),
        .pc_plus4   (pc_plus4),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    rv_execute execute_i (
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .src_a        (src_a),
        .alu_src_b    (alu_src_b),
        .alu_op       (alu_op),
        .funct3       (funct3),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    rv_pc_unit pc_unit_i (
        .CLK          (CLK),
        .RESET_N      (RESET_N),
        .branch       (branch),
        .branch_taken (branch_taken),
        .jump         (jump),
        .jump_reg     (jump_reg),
        .imm          (imm),
        .alu_result   (alu_result),
        .pc           (pc),
        .pc_plus4     (pc_plus4),
        .next_pc      ()
    );

    // word indices with the byte offset dropped
    assign ADDR_ROM = pc[ADDR_WIDTH+1:2];
    assign ADDR_RAM = alu_result[ADDR_WIDTH+1:2];
    assign Q_W      = rs2_data;
    assign ENABLE_W = mem_write;

endmodule

// ==== src/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN           = 32;
    // word index on the ROM and RAM ports
    localparam int ADDR_WIDTH     = 10;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
    localparam int SHAMT_WIDTH    = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    // operand A source, zero for LUI and pc for AUIPC
    typedef enum logic [1:0] {
        SRC_A_REG  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

// ==== src/rv_decoder.sv ====
module rv_decoder
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0] instr,
    output logic            reg_write,
    output logic            mem_write,
    output logic            alu_src_b,
    output logic            branch,
    output logic            jump,
    output logic            jump_reg,
    output src_a_e          src_a,
    output wb_sel_e         wb_sel,
    output alu_op_e         alu_op
);

    opcode_e                 opcode;
    logic [FUNCT3_WIDTH-1:0] funct3;
    logic                    alt;
    alu_op_e                 arith_op;

    assign opcode = opcode_e'(instr[OPCODE_LSB +: $bits(opcode_e)]);
    assign funct3 = instr[FUNCT3_LSB +: FUNCT3_WIDTH];
    assign alt    = instr[FUNCT7_ALT_BIT];

    // alu operation for OP and OP_IMM
    always_comb begin
        case (funct3)
            // no SUBI, bit 30 is part of the immediate there
            F3_ADD:  arith_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR:   arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        reg_write = 1'b0;
        mem_write = 1'b0;
        alu_src_b = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jump_reg  = 1'b0;
        src_a     = SRC_A_REG;
        wb_sel    = WB_ALU;
        alu_op    = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                src_a     = SRC_A_ZERO;
            end
            OPC_AUIPC: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                src_a     = SRC_A_PC;
            end
            OPC_JAL: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = WB_PC4;
            end
            // target comes out of the alu as rs1 + imm
            OPC_JALR: begin
                reg_write = 1'b1;
                jump_reg  = 1'b1;
                alu_src_b = 1'b1;
                wb_sel    = WB_PC4;
            end
            OPC_BRANCH: begin
                branch = 1'b1;
            end
            OPC_LOAD: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                wb_sel    = WB_MEM;
            end
            OPC_STORE: begin
                mem_write = 1'b1;
                alu_src_b = 1'b1;
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                alu_op    = arith_op;
            end
            OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = arith_op;
            end
            default: begin
                // unknown opcode retires as a no-op
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/rv_execute.sv ====
module rv_execute
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0]         pc,
    input  logic [XLEN-1:0]         rs1_data,
    input  logic [XLEN-1:0]         rs2_data,
    input  logic [XLEN-1:0]         imm,
    input  src_a_e                  src_a,
    input  logic                    alu_src_b,
    input  alu_op_e                 alu_op,
    input  logic [FUNCT3_WIDTH-1:0] funct3,
    output logic [XLEN-1:0]         alu_result,
    output logic                    branch_taken
);

    logic [XLEN-1:0]        op_a;
    logic [XLEN-1:0]        op_b;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic                   eq;
    logic                   lt;
    logic                   ltu;

    always_comb begin
        case (src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b  = alu_src_b ? imm : rs2_data;
    assign shamt = op_b[SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // branch compare runs on the register values, the alu stays free
    assign eq  = rs1_data == rs2_data;
    assign lt  = $signed(rs1_data) < $signed(rs2_data);
    assign ltu = rs1_data < rs2_data;

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = eq;
            F3_BNE:  branch_taken = !eq;
            F3_BLT:  branch_taken = lt;
            F3_BGE:  branch_taken = !lt;
            F3_BLTU: branch_taken = ltu;
            F3_BGEU: branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== src/rv_imm_gen.sv ====
module rv_imm_gen
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic [XLEN-1:0] instr,
    output logic [XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(instr[OPCODE_LSB +: $bits(opcode_e)]);

    always_comb begin
        case (opcode)
            // I format, shift amounts sit in the low bits
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // bit positions of the fixed instruction fields
    localparam int OPCODE_LSB     = 0;
    localparam int RD_LSB         = 7;
    localparam int FUNCT3_LSB     = 12;
    localparam int FUNCT3_WIDTH   = 3;
    localparam int RS1_LSB        = 15;
    localparam int RS2_LSB        = 20;
    // funct7 bit that selects SUB and SRA
    localparam int FUNCT7_ALT_BIT = 30;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // conditional branch funct3
    localparam logic [FUNCT3_WIDTH-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] F3_BGEU = 3'b111;

    // OP and OP_IMM funct3, F3_SR covers SRL and SRA
    localparam logic [FUNCT3_WIDTH-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_WIDTH-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_SR   = 3'b101;
    localparam logic [FUNCT3_WIDTH-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] F3_AND  = 3'b111;

endpackage

// ==== src/rv_pc_unit.sv ====
module rv_pc_unit
    import rv_core_pkg::*;
(
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic            branch,
    input  logic            branch_taken,
    input  logic            jump,
    input  logic            jump_reg,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pc_plus4,
    output logic [XLEN-1:0] next_pc
);

    logic [XLEN-1:0] target;

    assign pc_plus4 = pc + XLEN'(4);
    assign target   = pc + imm;

    always_comb begin
        if (jump_reg) begin
            // JALR clears the low bit of rs1 + imm
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else if (jump || (branch && branch_taken)) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// ==== src/rv_regfile.sv ====
module rv_regfile
    import rv_core_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET_N,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic                      reg_write,
    input  wb_sel_e                   wb_sel,
    input  logic [XLEN-1:0]           alu_result,
    input  logic [XLEN-1:0]           mem_data,
    input  logic [XLEN-1:0]           pc_plus4,
    output logic [XLEN-1:0]           rs1_data,
    output logic [XLEN-1:0]           rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] wb_data;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = mem_data;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    // x0 is cleared by reset and never written
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && rd_addr != '0) begin
            regs[rd_addr] <= wb_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// ==== testbench/tb_rv_core.sv ====
module tb_rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  CLK;
    logic                  RESET_N;
    logic [XLEN-1:0]       Q_ROM;
    logic [ADDR_WIDTH-1:0] ADDR_ROM;
    logic [ADDR_WIDTH-1:0] ADDR_RAM;
    logic [XLEN-1:0]       Q_RAM;
    logic [XLEN-1:0]       Q_W;
    logic                  ENABLE_W;

    logic [31:0] lfsr_state = 32'hf182f81d;
    int          prog_len = 0;
    int          dyn_count = 0;
    int          slot = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100000;
    int          mismatch_count = 0;
    int          fail_count = 0;

    // one backward loop shape per branch kind
    logic [2:0] kind_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    logic [4:0] loop_rs1 [6] = '{5'd17, 5'd13, 5'd0, 5'd13, 5'd0, 5'd13};
    logic [4:0] loop_rs2 [6] = '{5'd18, 5'd0, 5'd13, 5'd18, 5'd13, 5'd18};

    rv_core dut_i (.*);

    tb_rv_model model_i (.*);

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f, input logic [4:0] rd);
        return {f7, rs2, rs1, f, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [4:0] rs1,
            input logic [2:0] f, input logic [4:0] rd, input logic [6:0] op);
        return {im, rs1, f, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f);
        return {off[12], off[10:5], rs2, rs1, f, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        model_i.rom[prog_len] = word;
        prog_len++;
        dyn_count++;
    endtask

    // SW rs into the next result slot above x10
    task automatic store_slot(input logic [4:0] rs);
        logic [11:0] off;
        off = 12'(slot * 4);
        emit({off[11:5], rs, 5'd10, 3'b010, off[4:0], OPC_STORE});
        slot++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] c);
        logic [31:0] hi;
        hi = c + 32'h800;
        emit({hi[31:12], rd, OPC_LUI});
        emit(enc_i(c[11:0], rd, F3_ADD, rd, OPC_OP_IMM));
    endtask

    task automatic build_program();
        logic [11:0] im;
        logic [2:0]  f;
        logic [4:0]  r1;
        logic [4:0]  r2;
        int          n;
        int          start;
        int          stored;
        for (int i = 0; i < (1 << ADDR_WIDTH); i++) begin
            model_i.rom[i] = enc_i(12'(i), 5'd0, F3_ADD, 5'd0, OPC_OP_IMM);
        end
        for (int r = 1; r <= 4; r++) begin
            load_const(5'(r), rand_bits(32));
        end
        emit(enc_i(12'h100, 5'd0, F3_ADD, 5'd10, OPC_OP_IMM));
        for (int p = 0; p < 2; p++) begin
            r1 = 5'(1 + 2 * p);
            r2 = 5'(2 + 2 * p);
            // eight funct3 codes then SUB and SRA
            for (int k = 0; k < 10; k++) begin
                f = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD : F3_SR);
                emit(enc_r((k >= 8) ? 7'h20 : 7'h00, r2, r1, f, 5'd11));
                store_slot(5'd11);
            end
            for (int k = 0; k < 9; k++) begin
                f = (k < 8) ? 3'(k) : F3_SR;
                im = 12'(rand_bits(12));
                if (f == F3_SLL || f == F3_SR) begin
                    im = {(k == 8) ? 7'h20 : 7'h00, im[4:0]};
                end
                emit(enc_i(im, r1, f, 5'd12, OPC_OP_IMM));
                store_slot(5'd12);
            end
        end
        emit({20'(rand_bits(20)), 5'd11, OPC_AUIPC});
        store_slot(5'd11);
        // a write to x0 must leave it zero
        emit(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd0));
        store_slot(5'd0);
        emit(enc_i(12'd1, 5'd0, F3_ADD, 5'd18, OPC_OP_IMM));
        for (int k = 0; k < 6; k++) begin
            n = 2 + int'(rand_bits(2));
            emit(enc_i(12'(n), 5'd0, F3_ADD, 5'd13, OPC_OP_IMM));
            start = prog_len;
            emit(enc_i(12'hfff, 5'd13, F3_ADD, 5'd13, OPC_OP_IMM));
            emit(enc_r(7'h00, 5'd13, 5'd19, F3_ADD, 5'd19));
            if (k == 0) begin
                emit(enc_r(7'h00, 5'd13, 5'd0, F3_SLTU, 5'd17));
            end
            emit(enc_b(13'((start - prog_len) * 4), loop_rs2[k], loop_rs1[k], kind_f3[k]));
            dyn_count += (n - 1) * (prog_len - start);
        end
        store_slot(5'd19);
        // each forward branch on the random constants skips one increment
        for (int k = 0; k < 6; k++) begin
            r1 = 5'(rand_bits(2));
            r2 = 5'(rand_bits(2));
            emit(enc_b(13'd8, r2, r1, kind_f3[k]));
            emit(enc_i(12'd1, 5'd16, F3_ADD, 5'd16, OPC_OP_IMM));
            store_slot(5'd16);
        end
        // call and return through x20
        emit(enc_j(21'd12, 5'd20));
        store_slot(5'd21);
        emit(enc_j(21'd12, 5'd0));
        emit(enc_i(12'd77, 5'd0, F3_ADD, 5'd21, OPC_OP_IMM));
        emit(enc_i(12'd0, 5'd20, 3'b000, 5'd0, OPC_JALR));
        store_slot(5'd20);
        stored = slot;
        for (int s = 0; s < stored; s++) begin
            emit(enc_i(12'(s * 4), 5'd10, 3'b010, 5'd22, OPC_LOAD));
            store_slot(5'd22);
        end
        emit(enc_j(21'd0, 5'd0));
        cycle_limit = dyn_count + 50;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatch_count++;
        $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    always @(posedge CLK) begin
        if (!RESET_N) begin
            assert (!ENABLE_W) else begin
                fail_count++;
                $display("write enable was high during reset at %0d ns", $time);
            end
        end else begin
            assert (ADDR_ROM == model_i.pc[ADDR_WIDTH+1:2])
                else report_mismatch("ADDR_ROM", 32'(ADDR_ROM), 32'(model_i.pc[ADDR_WIDTH+1:2]));
            assert (ENABLE_W == model_i.st)
                else report_mismatch("ENABLE_W", 32'(ENABLE_W), 32'(model_i.st));
            if (model_i.st || model_i.ld) begin
                assert (ADDR_RAM == model_i.ea[ADDR_WIDTH+1:2])
                    else report_mismatch("ADDR_RAM", 32'(ADDR_RAM),
                                         32'(model_i.ea[ADDR_WIDTH+1:2]));
            end
            if (model_i.st) begin
                assert (Q_W == model_i.b) else report_mismatch("Q_W", Q_W, model_i.b);
            end
            if (model_i.halted) begin
                assert (!ENABLE_W) else begin
                    fail_count++;
                    $display("write enable was high in the final loop at %0d ns", $time);
                end
            end
        end
    end

    always @(posedge CLK) begin
        if (RESET_N) begin
            cycle_count++;
        end
        if (cycle_count > cycle_limit) begin
            $display("timeout: the program did not reach its final loop in %0d cycles",
                     cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        RESET_N = 1'b0;
        build_program();
        repeat (4) @(posedge CLK);
        #5 RESET_N = 1'b1;
        while (!model_i.halted) begin
            @(posedge CLK);
        end
        // a few cycles in the self-loop
        repeat (3) @(posedge CLK);
        #5;
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_rv_model.sv ====
module tb_rv_model
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic [ADDR_WIDTH-1:0] ADDR_ROM,
    input  logic [ADDR_WIDTH-1:0] ADDR_RAM,
    input  logic [XLEN-1:0]       Q_W,
    input  logic                  ENABLE_W,
    output logic [XLEN-1:0]       Q_ROM,
    output logic [XLEN-1:0]       Q_RAM
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS = 1 << ADDR_WIDTH;

    logic [XLEN-1:0] rom [MEM_WORDS];
    logic [XLEN-1:0] ram [MEM_WORDS];
    logic [XLEN-1:0] ref_ram [MEM_WORDS];
    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] wv;
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] ea;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [2:0]      f3;
    logic            wr;
    logic            st;
    logic            ld;
    logic            halted;

    // ALU result by the ISA tables
    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f, input logic alt,
                                                input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
        case (f)
            F3_ADD:  return alt ? x - y : x + y;
            F3_SLL:  return x << y[4:0];
            F3_SLT:  return {31'b0, $signed(x) < $signed(y)};
            F3_SLTU: return {31'b0, x < y};
            F3_XOR:  return x ^ y;
            F3_SR:   return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            F3_OR:   return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic taken_ref(input logic [2:0] f, input logic [XLEN-1:0] x,
                                       input logic [XLEN-1:0] y);
        case (f)
            F3_BEQ:  return x == y;
            F3_BNE:  return x != y;
            F3_BLT:  return $signed(x) < $signed(y);
            F3_BGE:  return $signed(x) >= $signed(y);
            F3_BLTU: return x < y;
            F3_BGEU: return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // memory contents before the program touches them
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = 32'(i) * 32'h9e3779b9 ^ 32'h5a5a0000;
            ref_ram[i] = 32'(i) * 32'h9e3779b9 ^ 32'h5a5a0000;
        end
    end

    assign Q_ROM = rom[ADDR_ROM];
    assign Q_RAM = ram[ADDR_RAM];

    always @(posedge CLK) begin
        if (ENABLE_W) begin
            ram[ADDR_RAM] <= Q_W;
        end
    end

    assign instr  = rom[pc[ADDR_WIDTH+1:2]];
    assign f3     = instr[14:12];
    assign a      = regs[instr[19:15]];
    assign b      = regs[instr[24:20]];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    // final self-loop is JAL x0, 0
    assign halted = instr == 32'h0000006f;

    always_comb begin
        wr  = 1'b0;
        st  = 1'b0;
        ld  = 1'b0;
        wv  = '0;
        ea  = '0;
        npc = pc + 32'd4;
        case (opcode_e'(instr[6:0]))
            OPC_LUI: begin
                wr = 1'b1;
                wv = imm_u;
            end
            OPC_AUIPC: begin
                wr = 1'b1;
                wv = pc + imm_u;
            end
            OPC_JAL: begin
                wr  = 1'b1;
                wv  = pc + 32'd4;
                npc = pc + imm_j;
            end
            OPC_JALR: begin
                wr  = 1'b1;
                wv  = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                if (taken_ref(f3, a, b)) begin
                    npc = pc + imm_b;
                end
            end
            OPC_LOAD: begin
                wr = 1'b1;
                ld = 1'b1;
                ea = a + imm_i;
                wv = ref_ram[ea[ADDR_WIDTH+1:2]];
            end
            OPC_STORE: begin
                st = 1'b1;
                ea = a + imm_s;
            end
            OPC_OP_IMM: begin
                wr = 1'b1;
                wv = alu_ref(f3, f3 == F3_SR && instr[30], a, imm_i);
            end
            OPC_OP: begin
                wr = 1'b1;
                wv = alu_ref(f3, instr[30], a, b);
            end
            default: begin
                wr = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            pc <= npc;
            if (wr && instr[11:7] != 5'd0) begin
                regs[instr[11:7]] <= wv;
            end
            if (st) begin
                ref_ram[ea[ADDR_WIDTH+1:2]] <= b;
            end
        end
    end

endmodule
